/* compile.f */
src/mips_isa_pkg.sv
src/id_stage_pkg.sv
src/regfile.sv
src/operand_forward.sv
src/inst_decoder.sv
src/branch_resolve.sv
src/id_stage_top.sv
dv/tb_id_stage.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_id_stage
FILELIST   := compile.f
FLAGS      := --binary --timing --timescale 1ns/1ns
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ns
OBJ_DIR    := obj_dir
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF '=== PASS ==='

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage;

    import id_stage_pkg::*;

    localparam int          NUM_FWD_SRC = 3;
    localparam int          MAX_CYCLES  = 2000;   // well past the length of all tests
    localparam logic [31:0] BR_PC       = 32'h0040_1000;

    logic                              clk;
    logic                              rst_n;
    logic                              inst_valid;
    logic [31:0]                       pc;
    logic [31:0]                       inst;
    logic                              stall;
    logic                              flush;
    reg_write_t                        wb;
    reg_write_t [NUM_FWD_SRC-1:0]      fwd;
    branch_t                           branch;
    id_ex_t                            id_ex;

    logic [31:0] shadow [32];   // expected register file contents
    branch_t     br_seen;
    int          err_cnt  = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycles   = 0;

    id_stage_top #(
        .NUM_FWD_SRC (NUM_FWD_SRC)
    ) dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .pc_i         (pc),
        .inst_i       (inst),
        .stall_i      (stall),
        .flush_i      (flush),
        .wb_i         (wb),
        .fwd_i        (fwd),
        .branch_o     (branch),
        .id_ex_o      (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // instruction encoders, field layout of the MIPS32 ISA
    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] funct);
        return {6'h00, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] branch_target(input logic [31:0] at_pc,
                                                  input logic [15:0] off);
        return at_pc + 32'd4 + (sext16(off) << 2);
    endfunction

    function automatic logic [31:0] jump_target(input logic [31:0] at_pc,
                                                input logic [25:0] index);
        logic [31:0] next_pc;
        next_pc = at_pc + 32'd4;
        return {next_pc[31:28], index, 2'b00};
    endfunction

    function automatic reg_write_t make_wr(input logic we, input logic [4:0] idx,
                                           input logic [31:0] data);
        reg_write_t wr;
        wr.we   = we;
        wr.idx  = idx;
        wr.data = data;
        return wr;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%-16s ok", name);
        end else begin
            fail_cnt++;
            $display("%-16s failed with %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    // write lands at the second edge
    task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
        @(posedge clk);
        wb <= make_wr(1'b1, idx, data);
        @(posedge clk);
        wb <= make_wr(1'b0, 5'd0, 32'd0);
        if (idx != 5'd0) begin
            shadow[idx] = data;
        end
    endtask

    // one cycle in decode, then one cycle of ID/EX latency
    task automatic issue(input logic [31:0] at_pc, input logic [31:0] word);
        @(posedge clk);
        inst_valid <= 1'b1;
        pc         <= at_pc;
        inst       <= word;
        @(negedge clk);
        br_seen = branch;   // combinational, same cycle
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check("id_ex.valid", 32'(id_ex.valid), 32'd1);
    endtask

    task automatic check_alu(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] dest);
        check("id_ex.alu_op", 32'(id_ex.alu_op), 32'(op));
        check("id_ex.operand_a", id_ex.operand_a, a);
        check("id_ex.operand_b", id_ex.operand_b, b);
        check("id_ex.we", 32'(id_ex.we), 32'd1);
        check("id_ex.dest", 32'(id_ex.dest), 32'(dest));
    endtask

    task automatic run_branch(input logic [31:0] word, input logic exp_taken);
        issue(BR_PC, word);
        check("branch.taken", 32'(br_seen.taken), 32'(exp_taken));
        check("branch.target", br_seen.target, branch_target(BR_PC, word[15:0]));
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = err_cnt;
        @(negedge clk);
        check("id_ex.valid", 32'(id_ex.valid), 32'd0);
        check("branch.taken", 32'(branch.taken), 32'd0);
        repeat (3) begin
            issue(32'h0040_0000, rtype(5'($urandom), 5'($urandom), 5'd3, 5'd0, 6'h21));
            check_alu(ALU_ADDU, 32'd0, 32'd0, 5'd3);
        end
        end_test("reset_state", e0);
    endtask

    task automatic test_wb_read();
        int e0;
        e0 = err_cnt;
        for (int i = 1; i <= 4; i++) begin
            write_reg(5'(i), $urandom);
        end
        write_reg(5'd0, 32'hdead_beef);   // must be dropped
        issue(32'h0040_0010, rtype(5'd1, 5'd2, 5'd5, 5'd0, 6'h21));
        check_alu(ALU_ADDU, shadow[1], shadow[2], 5'd5);
        issue(32'h0040_0014, rtype(5'd3, 5'd4, 5'd6, 5'd0, 6'h25));
        check_alu(ALU_OR, shadow[3], shadow[4], 5'd6);
        issue(32'h0040_0018, rtype(5'd4, 5'd1, 5'd7, 5'd0, 6'h2a));
        check_alu(ALU_SLT, shadow[4], shadow[1], 5'd7);
        issue(32'h0040_001c, rtype(5'd0, 5'd1, 5'd8, 5'd0, 6'h21));
        check_alu(ALU_ADDU, 32'd0, shadow[1], 5'd8);
        end_test("wb_read", e0);
    endtask

    task automatic test_forwarding();
        int          e0;
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] v2;
        e0 = err_cnt;
        write_reg(5'd5, $urandom);
        write_reg(5'd6, $urandom);
        v0 = $urandom;
        v1 = $urandom;
        v2 = $urandom;
        @(posedge clk);
        fwd[0] <= make_wr(1'b1, 5'd5, v0);
        fwd[1] <= make_wr(1'b1, 5'd5, v1);
        fwd[2] <= make_wr(1'b1, 5'd5, v2);
        issue(32'h0040_0100, rtype(5'd5, 5'd6, 5'd7, 5'd0, 6'h21));
        check_alu(ALU_ADDU, v0, shadow[6], 5'd7);
        @(posedge clk);
        fwd[0] <= make_wr(1'b0, 5'd5, v0);   // ex entry disabled
        issue(32'h0040_0104, rtype(5'd5, 5'd6, 5'd7, 5'd0, 6'h21));
        check_alu(ALU_ADDU, v1, shadow[6], 5'd7);
        @(posedge clk);
        fwd[1] <= make_wr(1'b1, 5'd9, v1);
        issue(32'h0040_0108, rtype(5'd5, 5'd6, 5'd7, 5'd0, 6'h21));
        check_alu(ALU_ADDU, v2, shadow[6], 5'd7);
        @(posedge clk);
        fwd[2] <= make_wr(1'b1, 5'd6, v2);   // now only rt matches
        issue(32'h0040_010c, rtype(5'd5, 5'd6, 5'd7, 5'd0, 6'h21));
        check_alu(ALU_ADDU, shadow[5], v2, 5'd7);
        @(posedge clk);
        fwd[0] <= make_wr(1'b1, 5'd0, v0);
        issue(32'h0040_0110, rtype(5'd0, 5'd5, 5'd7, 5'd0, 6'h21));
        check_alu(ALU_ADDU, 32'd0, shadow[5], 5'd7);
        @(posedge clk);
        fwd <= '0;
        end_test("forwarding", e0);
    endtask

    task automatic test_imm_mem();
        int e0;
        e0 = err_cnt;
        write_reg(5'd5, $urandom);
        write_reg(5'd6, $urandom);
        issue(32'h0040_0200, itype(6'h0d, 5'd5, 5'd7, 16'h8001));   // ori
        check_alu(ALU_OR, shadow[5], 32'h0000_8001, 5'd7);
        issue(32'h0040_0204, itype(6'h09, 5'd5, 5'd7, 16'hfff0));   // addiu
        check_alu(ALU_ADDU, shadow[5], sext16(16'hfff0), 5'd7);
        issue(32'h0040_0208, itype(6'h0f, 5'd0, 5'd7, 16'h1234));   // lui
        check_alu(ALU_LUI, 32'd0, 32'h1234_0000, 5'd7);
        issue(32'h0040_020c, rtype(5'd0, 5'd5, 5'd8, 5'd7, 6'h00));   // sll by 7
        check_alu(ALU_SLL, shadow[5], 32'd7, 5'd8);
        issue(32'h0040_0210, itype(6'h23, 5'd5, 5'd9, 16'hfff8));   // lw
        check("id_ex.mem_addr", id_ex.mem_addr, shadow[5] + sext16(16'hfff8));
        check("id_ex.mem_op", 32'(id_ex.mem_op), 32'(MEM_LW));
        check("id_ex.we", 32'(id_ex.we), 32'd1);
        check("id_ex.dest", 32'(id_ex.dest), 32'd9);
        issue(32'h0040_0214, itype(6'h2b, 5'd5, 5'd6, 16'h000c));   // sw
        check("id_ex.mem_addr", id_ex.mem_addr, shadow[5] + 32'd12);
        check("id_ex.mem_op", 32'(id_ex.mem_op), 32'(MEM_SW));
        check("id_ex.we", 32'(id_ex.we), 32'd0);
        check("id_ex.store_data", id_ex.store_data, shadow[6]);
        end_test("imm_mem", e0);
    endtask

    task automatic test_branches();
        int          e0;
        logic [31:0] jpc;
        e0  = err_cnt;
        jpc = 32'h1fff_fffc;   // pc+4 crosses into the next region
        write_reg(5'd10, 32'd0);
        write_reg(5'd11, ($urandom & 32'h7fff_ffff) | 32'd1);
        write_reg(5'd12, shadow[11] | 32'h8000_0000);
        write_reg(5'd13, shadow[11]);
        write_reg(5'd14, $urandom & 32'hffff_fffc);
        run_branch(itype(6'h04, 5'd11, 5'd13, 16'h0010), shadow[11] == shadow[13]);
        run_branch(itype(6'h04, 5'd11, 5'd12, 16'hfff0), shadow[11] == shadow[12]);
        run_branch(itype(6'h05, 5'd11, 5'd12, 16'h0020), shadow[11] != shadow[12]);
        run_branch(itype(6'h05, 5'd11, 5'd13, 16'h0020), shadow[11] != shadow[13]);
        run_branch(itype(6'h07, 5'd11, 5'd0, 16'h0004), $signed(shadow[11]) > 0);   // bgtz
        run_branch(itype(6'h07, 5'd10, 5'd0, 16'h0004), $signed(shadow[10]) > 0);
        run_branch(itype(6'h07, 5'd12, 5'd0, 16'h0004), $signed(shadow[12]) > 0);
        run_branch(itype(6'h06, 5'd10, 5'd0, 16'hff00), $signed(shadow[10]) <= 0);  // blez
        run_branch(itype(6'h06, 5'd12, 5'd0, 16'hff00), $signed(shadow[12]) <= 0);
        run_branch(itype(6'h06, 5'd11, 5'd0, 16'hff00), $signed(shadow[11]) <= 0);
        run_branch(itype(6'h01, 5'd12, 5'd0, 16'h0008), $signed(shadow[12]) < 0);   // bltz
        run_branch(itype(6'h01, 5'd10, 5'd0, 16'h0008), $signed(shadow[10]) < 0);
        run_branch(itype(6'h01, 5'd10, 5'd1, 16'h0008), $signed(shadow[10]) >= 0);  // bgez
        run_branch(itype(6'h01, 5'd12, 5'd1, 16'h0008), $signed(shadow[12]) >= 0);
        issue(jpc, {6'h02, 26'h012_3456});   // j
        check("branch.taken", 32'(br_seen.taken), 32'd1);
        check("branch.target", br_seen.target, jump_target(jpc, 26'h012_3456));
        issue(jpc, {6'h03, 26'h3ab_cdef});   // jal
        check("branch.taken", 32'(br_seen.taken), 32'd1);
        check("branch.target", br_seen.target, jump_target(jpc, 26'h3ab_cdef));
        check("id_ex.alu_op", 32'(id_ex.alu_op), 32'(ALU_LINK));
        check("id_ex.operand_a", id_ex.operand_a, jpc + 32'd8);
        check("id_ex.dest", 32'(id_ex.dest), 32'd31);
        check("id_ex.we", 32'(id_ex.we), 32'd1);
        issue(BR_PC, rtype(5'd14, 5'd0, 5'd0, 5'd0, 6'h08));   // jr
        check("branch.taken", 32'(br_seen.taken), 32'd1);
        check("branch.target", br_seen.target, shadow[14]);
        check("id_ex.we", 32'(id_ex.we), 32'd0);
        end_test("branches", e0);
    endtask

    task automatic test_pipeline_ctrl();
        int e0;
        e0 = err_cnt;
        @(posedge clk);
        inst_valid <= 1'b1;
        pc         <= 32'h0040_2000;
        inst       <= rtype(5'd1, 5'd2, 5'd3, 5'd0, 6'h21);
        @(posedge clk);   // first instruction enters ID/EX
        pc    <= 32'h0040_2004;
        inst  <= rtype(5'd2, 5'd1, 5'd4, 5'd0, 6'h23);
        stall <= 1'b1;
        @(negedge clk);
        check("id_ex.pc", id_ex.pc, 32'h0040_2000);
        @(posedge clk);
        @(negedge clk);
        check("id_ex.pc", id_ex.pc, 32'h0040_2000);   // held through the stall
        check("id_ex.valid", 32'(id_ex.valid), 32'd1);
        check("id_ex.dest", 32'(id_ex.dest), 32'd3);
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush      <= 1'b0;
        inst_valid <= 1'b0;
        @(negedge clk);
        check("id_ex.valid", 32'(id_ex.valid), 32'd0);
        issue(32'h0040_2008, {6'h3f, 26'h0ab_cdef});   // no such opcode
        check("id_ex.invalid", 32'(id_ex.invalid), 32'd1);
        check("id_ex.we", 32'(id_ex.we), 32'd0);
        check("branch.taken", 32'(br_seen.taken), 32'd0);
        issue(32'h0040_200c, rtype(5'd1, 5'd2, 5'd3, 5'd0, 6'h3f));   // bad funct
        check("id_ex.invalid", 32'(id_ex.invalid), 32'd1);
        check("id_ex.we", 32'(id_ex.we), 32'd0);
        end_test("pipeline_ctrl", e0);
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        pc         = '0;
        inst       = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        wb         = '0;
        fwd        = '0;
        void'($urandom(32'had6f));
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_wb_read();
        test_forwarding();
        test_imm_mem();
        test_branches();
        test_pipeline_ctrl();

        $display("summary: %0d tests passed, %0d failed, %0d mismatches",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* src/id_stage_top.sv */
`timescale 1ns/1ns

module id_stage_top #(
    parameter int NUM_FWD_SRC = 3
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        inst_valid_i,
    input  logic [31:0]                                 pc_i,
    input  logic [31:0]                                 inst_i,
    input  logic                                        stall_i,
    input  logic                                        flush_i,
    input  id_stage_pkg::reg_write_t                    wb_i,
    input  id_stage_pkg::reg_write_t [NUM_FWD_SRC-1:0]  fwd_i,   // 0 = ex, newest
    output id_stage_pkg::branch_t                       branch_o,
    output id_stage_pkg::id_ex_t                        id_ex_o
);

    import mips_isa_pkg::*;
    import id_stage_pkg::*;

    reg_idx_t     src_idx  [2];
    logic [31:0]  raw_data [2];
    logic [31:0]  fwd_data [2];
    id_ex_t       decoded;
    branch_kind_e kind;
    logic         ex_valid;
    id_ex_t       ex_payload;

    assign src_idx[0] = inst_i[25:21];   // rs
    assign src_idx[1] = inst_i[20:16];   // rt

    regfile u_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .raddr_i (src_idx),
        .rdata_o (raw_data),
        .wr_i    (wb_i)
    );

    for (genvar k = 0; k < 2; k++) begin : g_fwd
        operand_forward #(
            .NUM_FWD_SRC (NUM_FWD_SRC)
        ) u_fwd (
            .addr_i     (src_idx[k]),
            .reg_data_i (raw_data[k]),
            .fwd_i      (fwd_i),
            .data_o     (fwd_data[k])
        );
    end

    inst_decoder u_decoder (
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .rs_data_i (fwd_data[0]),
        .rt_data_i (fwd_data[1]),
        .valid_i   (inst_valid_i),
        .decoded_o (decoded),
        .kind_o    (kind)
    );

    branch_resolve u_branch (
        .kind_i    (kind),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .rs_data_i (fwd_data[0]),
        .rt_data_i (fwd_data[1]),
        .valid_i   (inst_valid_i),
        .branch_o  (branch_o)
    );

    // flush wins over a new instruction, stall freezes the slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            ex_valid <= 1'b0;
        end else if (!stall_i) begin
            ex_valid <= decoded.valid;   // bubble when nothing arrives
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_payload <= decoded;
        end
    end

    always_comb begin
        id_ex_o       = ex_payload;
        id_ex_o.valid = ex_valid;
    end

endmodule

/* src/branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve (
    input  id_stage_pkg::branch_kind_e  kind_i,
    input  logic [31:0]                 pc_i,
    input  logic [31:0]                 inst_i,
    input  logic [31:0]                 rs_data_i,
    input  logic [31:0]                 rt_data_i,
    input  logic                        valid_i,
    output id_stage_pkg::branch_t       branch_o
);

    import id_stage_pkg::*;

    logic [31:0] pc_plus4;
    logic [31:0] br_target;
    logic [31:0] jump_target;
    logic        cond;
    logic        rs_zero;

    assign pc_plus4    = pc_i + 32'd4;
    assign br_target   = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jump_target = {pc_plus4[31:28], inst_i[25:0], 2'b00};   // same 256MB region
    assign rs_zero     = (rs_data_i == 32'd0);

    always_comb begin
        case (kind_i)
            BR_BEQ:  cond = (rs_data_i == rt_data_i);
            BR_BNE:  cond = (rs_data_i != rt_data_i);
            BR_BLEZ: cond = rs_data_i[31] || rs_zero;
            BR_BGTZ: cond = !rs_data_i[31] && !rs_zero;
            BR_BLTZ: cond = rs_data_i[31];
            BR_BGEZ: cond = !rs_data_i[31];
            BR_J,
            BR_JR:   cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        branch_o.taken = valid_i && cond;
        if (kind_i == BR_J) begin
            branch_o.target = jump_target;
        end else if (kind_i == BR_JR) begin
            branch_o.target = rs_data_i;
        end else if (kind_i == BR_NONE) begin
            branch_o.target = pc_plus4;   // fall through
        end else begin
            branch_o.target = br_target;
        end
    end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
    input  logic [31:0]                 pc_i,
    input  logic [31:0]                 inst_i,
    input  logic [31:0]                 rs_data_i,
    input  logic [31:0]                 rt_data_i,
    input  logic                        valid_i,
    output id_stage_pkg::id_ex_t        decoded_o,
    output id_stage_pkg::branch_kind_e  kind_o
);

    import mips_isa_pkg::*;
    import id_stage_pkg::*;

    opcode_e     op;
    funct_e      funct;
    regimm_e     rimm;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] shamt;
    logic [31:0] pc_plus8;
    alu_op_e     alu_op;
    mem_op_e     mem_op;
    logic        we;
    reg_idx_t    dest;
    logic        invalid;
    logic [31:0] opa;
    logic [31:0] opb;

    assign op       = opcode_e'(inst_i[31:26]);
    assign funct    = funct_e'(inst_i[5:0]);
    assign rimm     = regimm_e'(inst_i[20:16]);
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'h0, inst_i[15:0]};
    assign shamt    = {27'h0, inst_i[10:6]};
    assign pc_plus8 = pc_i + 32'd8;   // skips the delay slot

    always_comb begin
        alu_op  = ALU_NOP;
        mem_op  = MEM_NONE;
        we      = 1'b0;
        dest    = inst_i[20:16];   // rt unless told otherwise
        invalid = 1'b0;
        kind_o  = BR_NONE;
        opa     = rs_data_i;
        opb     = rt_data_i;
        case (op)
            OP_SPECIAL: begin
                we   = (funct != FN_JR);
                dest = inst_i[15:11];
                case (funct)
                    FN_SLL, FN_SLLV: alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV: alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV: alu_op = ALU_SRA;
                    FN_JR:           kind_o = BR_JR;
                    FN_JALR: begin
                        alu_op = ALU_LINK;
                        kind_o = BR_JR;
                    end
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_ADDU: alu_op = ALU_ADDU;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_SUBU: alu_op = ALU_SUBU;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: invalid = 1'b1;
                endcase
            end
            OP_REGIMM: begin
                case (rimm)
                    RI_BLTZ: kind_o = BR_BLTZ;
                    RI_BGEZ: kind_o = BR_BGEZ;
                    default: invalid = 1'b1;
                endcase
            end
            OP_J:   kind_o = BR_J;
            OP_JAL: begin
                kind_o = BR_J;
                alu_op = ALU_LINK;
                we     = 1'b1;
                dest   = 5'd31;
            end
            OP_BEQ:   kind_o = BR_BEQ;
            OP_BNE:   kind_o = BR_BNE;
            OP_BLEZ:  kind_o = BR_BLEZ;
            OP_BGTZ:  kind_o = BR_BGTZ;
            OP_ADDI:  alu_op = ALU_ADD;
            OP_ADDIU: alu_op = ALU_ADDU;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI:  alu_op = ALU_AND;
            OP_ORI:   alu_op = ALU_OR;
            OP_XORI:  alu_op = ALU_XOR;
            OP_LUI:   alu_op = ALU_LUI;
            OP_LB:    mem_op = MEM_LB;
            OP_LBU:   mem_op = MEM_LBU;
            OP_LH:    mem_op = MEM_LH;
            OP_LHU:   mem_op = MEM_LHU;
            OP_LW:    mem_op = MEM_LW;
            OP_SB:    mem_op = MEM_SB;
            OP_SH:    mem_op = MEM_SH;
            OP_SW:    mem_op = MEM_SW;
            default:  invalid = 1'b1;
        endcase

        // immediate alu ops, logic ones (bit 2 set) zero-extend
        if (op[5:3] == 3'b001) begin
            we  = 1'b1;
            opb = (op == OP_LUI) ? {inst_i[15:0], 16'h0} : (op[2] ? imm_zext : imm_sext);
        end
        if (mem_op != MEM_NONE) begin
            alu_op = ALU_ADDU;
            opb    = imm_sext;
            we     = !op[3];   // stores start at 0x28
        end
        if (alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
            opa = rt_data_i;                     // value being shifted
            opb = funct[2] ? rs_data_i : shamt;  // shift amount
        end
        if (alu_op == ALU_LINK) begin
            opa = pc_plus8;
        end
        if (invalid) begin
            we = 1'b0;
        end
    end

    assign decoded_o = '{
        valid:      valid_i,
        pc:         pc_i,
        alu_op:     alu_op,
        operand_a:  opa,
        operand_b:  opb,
        store_data: rt_data_i,
        mem_op:     mem_op,
        mem_addr:   rs_data_i + imm_sext,
        we:         we,
        dest:       dest,
        invalid:    invalid
    };

endmodule

/* src/operand_forward.sv */
`timescale 1ns/1ns

module operand_forward #(
    parameter int NUM_FWD_SRC = 3
) (
    input  mips_isa_pkg::reg_idx_t                      addr_i,
    input  logic [31:0]                                 reg_data_i,
    input  id_stage_pkg::reg_write_t [NUM_FWD_SRC-1:0]  fwd_i,
    output logic [31:0]                                 data_o
);

    // index 0 is the youngest producer (ex), so walk from the
    // oldest down and let each younger match overwrite
    always_comb begin
        data_o = reg_data_i;
        for (int i = NUM_FWD_SRC - 1; i >= 0; i--) begin
            if (fwd_i[i].we && fwd_i[i].idx == addr_i) begin
                data_o = fwd_i[i].data;
            end
        end
        if (addr_i == 5'd0) begin
            data_o = '0;   // r0 never forwards
        end
    end

endmodule

/* src/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  mips_isa_pkg::reg_idx_t    raddr_i [2],
    output logic [31:0]               rdata_o [2],
    input  id_stage_pkg::reg_write_t  wr_i
);

    // r0 has no storage
    logic [31:0] regs [31:1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.idx != 5'd0) begin
            regs[wr_i.idx] <= wr_i.data;
        end
    end

    // read ports see the old value during a write,
    // the wb forwarding entry covers that case
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (raddr_i[p] == 5'd0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

/* src/id_stage_pkg.sv */
package id_stage_pkg;

    // operation handed to execute
    typedef enum logic [4:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_LUI,
        ALU_LINK    // passes operand_a through, return address
    } alu_op_e;

    // nine values, so four bits
    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_BLTZ, BR_BGEZ,
        BR_J, BR_JR
    } branch_kind_e;

    // writeback port and each forwarding source
    typedef struct packed {
        logic                   we;
        mips_isa_pkg::reg_idx_t idx;
        logic [31:0]            data;
    } reg_write_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branch_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        alu_op_e                alu_op;
        logic [31:0]            operand_a;
        logic [31:0]            operand_b;
        logic [31:0]            store_data;
        mem_op_e                mem_op;
        logic [31:0]            mem_addr;
        logic                   we;
        mips_isa_pkg::reg_idx_t dest;
        logic                   invalid;
    } id_ex_t;

endpackage

/* src/mips_isa_pkg.sv */
package mips_isa_pkg;

    // register file index, rs/rt/rd fields
    typedef logic [4:0] reg_idx_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        // immediate alu group, 0x08 to 0x0f
        OP_ADDI    = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI   = 6'h0d, OP_XORI = 6'h0e, OP_LUI   = 6'h0f,
        // loads
        OP_LB      = 6'h20, OP_LH    = 6'h21, OP_LW   = 6'h23,
        OP_LBU     = 6'h24, OP_LHU   = 6'h25,
        // stores
        OP_SB      = 6'h28, OP_SH    = 6'h29, OP_SW   = 6'h2b
    } opcode_e;

    // SPECIAL funct, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
        FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,   // bit 2 marks variable shift
        FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // REGIMM selector lives in the rt field
    typedef enum logic [4:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_e;

endpackage
